// ==== design/cache_pkg.sv ====
// --------------------------------------------------------------------------
// Data cache geometry and types
// --------------------------------------------------------------------------

package cache_pkg;

    // ----------------------------------------------------------------------
    // geometry
    // ----------------------------------------------------------------------
    localparam int unsigned NUM_WAYS   = 2;
    localparam int unsigned NUM_SETS   = 16;
    localparam int unsigned LINE_BYTES = 16;
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned WORD_WIDTH = 64;
    localparam int unsigned LINE_WIDTH = LINE_BYTES * 8;

    // address split: | tag | index | word | byte |
    localparam int unsigned OFFSET_WIDTH   = $clog2(LINE_BYTES);
    localparam int unsigned INDEX_WIDTH    = $clog2(NUM_SETS);
    localparam int unsigned TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int unsigned WORD_BYTES     = WORD_WIDTH / 8;
    localparam int unsigned BYTE_SEL_WIDTH = $clog2(WORD_BYTES);
    localparam int unsigned WORD_SEL_WIDTH = OFFSET_WIDTH - BYTE_SEL_WIDTH;

    // ----------------------------------------------------------------------
    // types
    // ----------------------------------------------------------------------
    typedef logic [NUM_WAYS-1:0]       way_vec_t;
    typedef logic [INDEX_WIDTH-1:0]    index_t;
    typedef logic [TAG_WIDTH-1:0]      tag_t;
    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [LINE_WIDTH-1:0]     line_t;
    typedef logic [WORD_BYTES-1:0]     word_be_t;
    typedef logic [WORD_SEL_WIDTH-1:0] word_sel_t;

    // one tag store entry
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

endpackage

// ==== design/sram_array.sv ====
// --------------------------------------------------------------------------
// Single-port synchronous array
// --------------------------------------------------------------------------

module sram_array #(
    parameter type entry_t = logic
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_i,
    input  logic              we_i,
    input  cache_pkg::index_t addr_i,
    input  entry_t            wdata_i,
    output entry_t            rdata_o
);
    import cache_pkg::*;

    localparam int unsigned DEPTH = NUM_SETS;

    entry_t mem_q [DEPTH];

    // storage, written on a request with we set
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
    end

    // registered read port, holds its value between reads
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_o <= '0;
        end else if (req_i && !we_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

// ==== design/tag_lookup.sv ====
// --------------------------------------------------------------------------
// Tag lookup and hit detection
// --------------------------------------------------------------------------

module tag_lookup (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                req_i,
    input  cache_pkg::index_t   index_i,
    input  cache_pkg::tag_t     tag_i,
    input  cache_pkg::way_vec_t we_way_i,
    input  cache_pkg::tag_t     wtag_i,
    output cache_pkg::way_vec_t hit_way_o,
    output cache_pkg::way_vec_t valid_way_o
);
    import cache_pkg::*;

    tag_entry_t                wentry;
    tag_entry_t [NUM_WAYS-1:0] rentry;
    way_vec_t   [NUM_SETS-1:0] valid_q;
    way_vec_t                  valid_rd_q;
    tag_t                      tag_q;

    // a written entry is always a fresh line
    assign wentry = '{valid: 1'b1, tag: wtag_i};

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
        sram_array #(
            .entry_t (tag_entry_t)
        ) tag_sram_i (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .req_i   (req_i | we_way_i[w]),
            .we_i    (we_way_i[w]),
            .addr_i  (index_i),
            .wdata_i (wentry),
            .rdata_o (rentry[w])
        );

        // compare against the tag captured with the read
        assign hit_way_o[w] = valid_rd_q[w] & rentry[w].valid & (rentry[w].tag == tag_q);
    end

    assign valid_way_o = valid_rd_q;

    // valid bits live in flops so reset empties the cache
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            valid_rd_q <= '0;
        end else begin
            if (req_i) begin
                valid_rd_q <= valid_q[index_i];
            end
            valid_q[index_i] <= valid_q[index_i] | we_way_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            tag_q <= tag_i;
        end
    end

endmodule

// ==== design/line_store.sv ====
// --------------------------------------------------------------------------
// Data line store
// --------------------------------------------------------------------------

module line_store (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                req_i,
    input  cache_pkg::index_t                   index_i,
    input  cache_pkg::way_vec_t                 we_way_i,
    input  logic                                refill_i,
    input  cache_pkg::line_t                    refill_line_i,
    input  cache_pkg::word_sel_t                word_sel_i,
    input  cache_pkg::word_be_t                 be_i,
    input  cache_pkg::word_t                    wdata_i,
    output cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] lines_o
);
    import cache_pkg::*;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
        line_t wline;

        // store hit: merge the word into the line read during lookup
        // refill: the whole line from memory
        always_comb begin : merge
            wline = lines_o[w];
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (be_i[b]) begin
                    wline[word_sel_i * WORD_WIDTH + b * 8 +: 8] = wdata_i[b * 8 +: 8];
                end
            end
            if (refill_i) begin
                wline = refill_line_i;
            end
        end

        sram_array #(
            .entry_t (line_t)
        ) data_sram_i (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .req_i   (req_i | we_way_i[w]),
            .we_i    (we_way_i[w]),
            .addr_i  (index_i),
            .wdata_i (wline),
            .rdata_o (lines_o[w])
        );
    end

endmodule

// ==== design/cache_ctrl.sv ====
// --------------------------------------------------------------------------
// Data cache controller
// --------------------------------------------------------------------------

module cache_ctrl (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    // core side
    input  logic                                       req_i,
    input  logic                                       we_i,
    input  cache_pkg::addr_t                           addr_i,
    input  cache_pkg::word_t                           wdata_i,
    input  cache_pkg::word_be_t                        be_i,
    input  logic                                       bypass_i,
    output logic                                       rvalid_o,
    output cache_pkg::word_t                           rdata_o,
    output logic                                       busy_o,
    // memory side
    output logic                                       mem_req_o,
    output logic                                       mem_we_o,
    output cache_pkg::addr_t                           mem_addr_o,
    output cache_pkg::word_t                           mem_wdata_o,
    output cache_pkg::word_be_t                        mem_be_o,
    input  logic                                       mem_rvalid_i,
    input  cache_pkg::line_t                           mem_rdata_i,
    // tag and line stores
    output logic                                       arr_req_o,
    output cache_pkg::index_t                          index_o,
    output cache_pkg::tag_t                            wtag_o,
    output cache_pkg::way_vec_t                        tag_we_way_o,
    output cache_pkg::way_vec_t                        data_we_way_o,
    output cache_pkg::word_sel_t                       word_sel_o,
    output cache_pkg::word_be_t                        be_o,
    output cache_pkg::word_t                           wdata_o,
    output logic                                       refill_o,
    output cache_pkg::line_t                           refill_line_o,
    input  cache_pkg::way_vec_t                        hit_way_i,
    input  cache_pkg::way_vec_t                        valid_way_i,
    input  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0] lines_i
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL
    } state_e;

    state_e              state_d, state_q;
    logic [NUM_SETS-1:0] ptr_q;
    logic                ptr_flip;
    way_vec_t            victim, victim_q;
    line_t               hit_line;

    // captured request
    logic      we_q;
    logic      bypass_q;
    addr_t     addr_q;
    word_t     wdata_q;
    word_be_t  be_q;
    index_t    req_index;
    tag_t      req_tag;
    word_sel_t req_word;

    assign req_index = addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_tag   = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign req_word  = addr_q[BYTE_SEL_WIDTH +: WORD_SEL_WIDTH];

    assign busy_o        = (state_q != IDLE);
    assign wtag_o        = req_tag;
    assign word_sel_o    = req_word;
    assign be_o          = be_q;
    assign wdata_o       = wdata_q;
    assign refill_line_o = mem_rdata_i;
    assign mem_wdata_o   = wdata_q;
    assign mem_be_o      = be_q;

    // line of the hitting way, zero on a miss
    always_comb begin : hit_mux
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_way_i[w]) begin
                hit_line = hit_line | lines_i[w];
            end
        end
    end

    // lowest invalid way first, else the set's pointer
    always_comb begin : victim_sel
        victim = way_vec_t'(1) << ptr_q[req_index];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_way_i[w]) begin
                victim = way_vec_t'(1) << w;
            end
        end
    end

    // ----------------------------------------------------------------------
    // request FSM
    // ----------------------------------------------------------------------
    always_comb begin : fsm
        state_d       = state_q;
        rvalid_o      = 1'b0;
        rdata_o       = '0;
        mem_req_o     = 1'b0;
        mem_we_o      = 1'b0;
        mem_addr_o    = '0;
        arr_req_o     = 1'b0;
        index_o       = req_index;
        tag_we_way_o  = '0;
        data_we_way_o = '0;
        refill_o      = 1'b0;
        ptr_flip      = 1'b0;

        case (state_q)
            IDLE: begin
                // every request looks up both stores
                index_o   = addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
                arr_req_o = req_i;
                if (req_i) begin
                    state_d = LOOKUP;
                end
            end

            LOOKUP: begin
                state_d = IDLE;
                if (we_q) begin
                    // write-through, a hitting line is updated even in bypass
                    // so later cached loads stay coherent
                    mem_req_o     = 1'b1;
                    mem_we_o      = 1'b1;
                    mem_addr_o    = {addr_q[ADDR_WIDTH-1:BYTE_SEL_WIDTH],
                                     {BYTE_SEL_WIDTH{1'b0}}};
                    rvalid_o      = 1'b1;
                    data_we_way_o = hit_way_i;
                end else if (|hit_way_i && !bypass_q) begin
                    rvalid_o = 1'b1;
                    rdata_o  = hit_line[req_word * WORD_WIDTH +: WORD_WIDTH];
                end else begin
                    // line read from memory
                    mem_req_o  = 1'b1;
                    mem_addr_o = {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
                    ptr_flip   = !bypass_q && (&valid_way_i);
                    state_d    = REFILL;
                end
            end

            REFILL: begin
                if (mem_rvalid_i) begin
                    rvalid_o = 1'b1;
                    rdata_o  = mem_rdata_i[req_word * WORD_WIDTH +: WORD_WIDTH];
                    if (!bypass_q) begin
                        tag_we_way_o  = victim_q;
                        data_we_way_o = victim_q;
                        refill_o      = 1'b1;
                    end
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            ptr_q   <= '0;
        end else begin
            state_q <= state_d;
            if (ptr_flip) begin
                ptr_q[req_index] <= ~ptr_q[req_index];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (arr_req_o) begin
            we_q     <= we_i;
            bypass_q <= bypass_i;
            addr_q   <= addr_i;
            wdata_q  <= wdata_i;
            be_q     <= be_i;
        end
        if (state_q == LOOKUP) begin
            victim_q <= victim;
        end
    end

endmodule

// ==== design/dcache_top.sv ====
// --------------------------------------------------------------------------
// Two-way data cache
// --------------------------------------------------------------------------

module dcache_top (
    input  logic                clk_i,
    input  logic                rst_ni,
    // core side
    input  logic                req_i,
    input  logic                we_i,
    input  cache_pkg::addr_t    addr_i,
    input  cache_pkg::word_t    wdata_i,
    input  cache_pkg::word_be_t be_i,
    input  logic                bypass_i,
    output logic                rvalid_o,
    output cache_pkg::word_t    rdata_o,
    output logic                busy_o,
    // memory side
    output logic                mem_req_o,
    output logic                mem_we_o,
    output cache_pkg::addr_t    mem_addr_o,
    output cache_pkg::word_t    mem_wdata_o,
    output cache_pkg::word_be_t mem_be_o,
    input  logic                mem_rvalid_i,
    input  cache_pkg::line_t    mem_rdata_i
);
    import cache_pkg::*;

    logic                  arr_req;
    index_t                index;
    tag_t                  lookup_tag;
    tag_t                  wtag;
    way_vec_t              tag_we_way;
    way_vec_t              data_we_way;
    way_vec_t              hit_way;
    way_vec_t              valid_way;
    word_sel_t             word_sel;
    word_be_t              be;
    word_t                 wdata;
    logic                  refill;
    line_t                 refill_line;
    line_t [NUM_WAYS-1:0]  lines;

    // tag of the incoming request, registered inside the lookup
    assign lookup_tag = addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];

    cache_ctrl cache_ctrl_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_i         (req_i),
        .we_i          (we_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .be_i          (be_i),
        .bypass_i      (bypass_i),
        .rvalid_o      (rvalid_o),
        .rdata_o       (rdata_o),
        .busy_o        (busy_o),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_be_o      (mem_be_o),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rdata_i   (mem_rdata_i),
        .arr_req_o     (arr_req),
        .index_o       (index),
        .wtag_o        (wtag),
        .tag_we_way_o  (tag_we_way),
        .data_we_way_o (data_we_way),
        .word_sel_o    (word_sel),
        .be_o          (be),
        .wdata_o       (wdata),
        .refill_o      (refill),
        .refill_line_o (refill_line),
        .hit_way_i     (hit_way),
        .valid_way_i   (valid_way),
        .lines_i       (lines)
    );

    tag_lookup tag_lookup_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (arr_req),
        .index_i     (index),
        .tag_i       (lookup_tag),
        .we_way_i    (tag_we_way),
        .wtag_i      (wtag),
        .hit_way_o   (hit_way),
        .valid_way_o (valid_way)
    );

    line_store line_store_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_i         (arr_req),
        .index_i       (index),
        .we_way_i      (data_we_way),
        .refill_i      (refill),
        .refill_line_i (refill_line),
        .word_sel_i    (word_sel),
        .be_i          (be),
        .wdata_i       (wdata),
        .lines_o       (lines)
    );

endmodule

// ==== test/mem_model.sv ====
// --------------------------------------------------------------------------
// Behavioral line memory
// --------------------------------------------------------------------------

module mem_model (
    input  logic                clk_i,
    input  logic                req_i,
    input  logic                we_i,
    input  cache_pkg::addr_t    addr_i,
    input  cache_pkg::word_t    wdata_i,
    input  cache_pkg::word_be_t be_i,
    output logic                rvalid_o,
    output cache_pkg::line_t    rdata_o
);
    import cache_pkg::*;

    localparam int MEM_BYTES = 4096;
    localparam int MAX_DELAY = 6;

    logic [7:0] mem_q [MEM_BYTES];

    initial begin : serve
        int unsigned wait_cycles;
        logic        pending;
        logic [11:0] base;
        logic [11:0] waddr;
        line_t       line;

        rvalid_o    <= 1'b0;
        rdata_o     <= '0;
        pending     = 1'b0;
        wait_cycles = 0;
        base        = '0;
        // every byte depends on its full 12-bit address
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem_q[12'(i)] = 8'(i) + 8'(i >> 8) * 8'd37;
        end
        forever begin
            @(posedge clk_i);
            rvalid_o <= 1'b0;
            if (req_i && we_i) begin
                // word writes land at once
                waddr = {addr_i[11:3], 3'b000};
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (be_i[b]) begin
                        mem_q[waddr + 12'(b)] = wdata_i[b * 8 +: 8];
                    end
                end
            end else if (req_i) begin
                pending     = 1'b1;
                wait_cycles = $urandom % MAX_DELAY;
                base        = {addr_i[11:4], 4'b0000};
            end
            if (pending) begin
                if (wait_cycles == 0) begin
                    for (int b = 0; b < LINE_BYTES; b++) begin
                        line[b * 8 +: 8] = mem_q[base + 12'(b)];
                    end
                    rvalid_o <= 1'b1;
                    rdata_o  <= line;
                    pending  = 1'b0;
                end else begin
                    wait_cycles--;
                end
            end
        end
    end

endmodule

// ==== test/dcache_tb.sv ====
// --------------------------------------------------------------------------
// Data cache testbench
// --------------------------------------------------------------------------

module dcache_tb;
    import cache_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int MEM_BYTES      = 4096;
    localparam int RANDOM_OPS     = 60;

    // expected outcome of a load
    localparam int EXPECT_MISS = 0;
    localparam int EXPECT_HIT  = 1;
    localparam int EXPECT_ANY  = 2;

    logic     clk_i;
    logic     rst_ni;
    logic     req_i;
    logic     we_i;
    addr_t    addr_i;
    word_t    wdata_i;
    word_be_t be_i;
    logic     bypass_i;
    logic     rvalid_o;
    word_t    rdata_o;
    logic     busy_o;
    logic     mem_req;
    logic     mem_we;
    addr_t    mem_addr;
    word_t    mem_wdata;
    word_be_t mem_be;
    logic     mem_rvalid;
    line_t    mem_rdata;

    logic [7:0] shadow [MEM_BYTES];

    dcache_top dcache_top_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (req_i),
        .we_i         (we_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .be_i         (be_i),
        .bypass_i     (bypass_i),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o),
        .busy_o       (busy_o),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_be_o     (mem_be),
        .mem_rvalid_i (mem_rvalid),
        .mem_rdata_i  (mem_rdata)
    );

    mem_model mem_model_i (
        .clk_i    (clk_i),
        .req_i    (mem_req),
        .we_i     (mem_we),
        .addr_i   (mem_addr),
        .wdata_i  (mem_wdata),
        .be_i     (mem_be),
        .rvalid_o (mem_rvalid),
        .rdata_o  (mem_rdata)
    );

    initial begin : clock
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------------------
    // protocol properties
    // ----------------------------------------------------------------------
    assert property (@(posedge clk_i) !rst_ni |-> !busy_o && !rvalid_o && !mem_req)
        else stop_on_error("busy_o, rvalid_o or mem_req_o high during reset");
    assert property (@(posedge clk_i) disable iff (!rst_ni) rvalid_o |-> busy_o ##1 !busy_o)
        else stop_on_error("busy_o not high with rvalid_o or not low after it");
    assert property (@(posedge clk_i) disable iff (!rst_ni) (mem_req && mem_we) |-> rvalid_o)
        else stop_on_error("store write request without rvalid_o in the same cycle");
    assert property (@(posedge clk_i) disable iff (!rst_ni) (mem_req && !mem_we) |-> !rvalid_o)
        else stop_on_error("load answered in the cycle of its memory read");
    assert property (@(posedge clk_i) disable iff (!rst_ni) mem_rvalid |-> rvalid_o)
        else stop_on_error("memory line returned without rvalid_o in the same cycle");

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else stop_on_error(what);
    endtask

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        assert (got === exp)
            else stop_on_error($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                         $time, name, got, exp));
    endtask

    function automatic logic [7:0] fill_byte(input logic [11:0] a);
        return a[7:0] + 8'(a[11:8]) * 8'd37;
    endfunction

    // memory wraps every 4 KiB
    function automatic word_t shadow_word(input addr_t addr);
        word_t       w;
        logic [11:0] base;
        base = {addr[11:3], 3'b000};
        for (int b = 0; b < WORD_BYTES; b++) begin
            w[b * 8 +: 8] = shadow[base + 12'(b)];
        end
        return w;
    endfunction

    task automatic shadow_write(input addr_t addr, input word_t wdata, input word_be_t be);
        logic [11:0] base;
        base = {addr[11:3], 3'b000};
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) begin
                shadow[base + 12'(b)] = wdata[b * 8 +: 8];
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        rst_ni <= 1'b0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        require(!busy_o && !rvalid_o && !mem_req, "outputs not quiet after reset");
    endtask

    // ----------------------------------------------------------------------
    // request driver
    // ----------------------------------------------------------------------
    task automatic run_request(
        input  logic     we,
        input  addr_t    addr,
        input  word_t    wdata,
        input  word_be_t be,
        input  logic     bypass,
        output word_t    rdata,
        output int       latency,
        output logic     mem_used
    );
        int   cycles;
        logic done;
        @(posedge clk_i);
        req_i    <= 1'b1;
        we_i     <= we;
        addr_i   <= addr;
        wdata_i  <= wdata;
        be_i     <= be;
        bypass_i <= bypass;
        @(posedge clk_i);
        req_i <= 1'b0;
        require(!busy_o, "request issued while busy_o was high");
        cycles   = 0;
        done     = 1'b0;
        mem_used = 1'b0;
        rdata    = '0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
            require(busy_o, "busy_o low while a request was open");
            if (mem_req) begin
                require(cycles == 1, "memory request not in the cycle after req_i");
                compare_value("mem_we_o", 64'(mem_we), 64'(we));
                if (we) begin
                    compare_value("mem_addr_o", 64'(mem_addr), 64'({addr[31:3], 3'b000}));
                    compare_value("mem_wdata_o", mem_wdata, wdata);
                    compare_value("mem_be_o", 64'(mem_be), 64'(be));
                end else begin
                    compare_value("mem_addr_o", 64'(mem_addr), 64'({addr[31:4], 4'b0000}));
                end
                mem_used = 1'b1;
            end
            if (rvalid_o) begin
                done  = 1'b1;
                rdata = rdata_o;
            end
        end
        if (!done) begin
            stop_on_error($sformatf("no rvalid_o within %0d cycles of a request",
                                    TIMEOUT_CYCLES));
        end
        latency = cycles;
    endtask

    task automatic load_word(input addr_t addr, input logic bypass, input int expect_kind);
        word_t rdata;
        int    latency;
        logic  mem_used;
        run_request(1'b0, addr, '0, '0, bypass, rdata, latency, mem_used);
        compare_value("rdata_o", rdata, shadow_word(addr));
        if (bypass || expect_kind == EXPECT_MISS) begin
            require(mem_used, "load that must miss issued no memory read");
        end
        if (expect_kind == EXPECT_HIT) begin
            require(!mem_used, "load that must hit read memory");
        end
        if (!mem_used) begin
            require(latency == 1, "load hit not answered in the cycle after req_i");
        end
    endtask

    task automatic store_word(input addr_t addr, input word_t wdata, input word_be_t be,
                              input logic bypass);
        word_t rdata;
        int    latency;
        logic  mem_used;
        run_request(1'b1, addr, wdata, be, bypass, rdata, latency, mem_used);
        require(mem_used, "store issued no memory write");
        require(latency == 1, "store not acknowledged in the cycle after req_i");
        compare_value("rdata_o", rdata, '0);
        shadow_write(addr, wdata, be);
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin : stimulus
        addr_t    addr;
        word_t    wdata;
        word_be_t be;
        logic     we;
        logic     bypass;

        void'($urandom(67));
        rst_ni   <= 1'b0;
        req_i    <= 1'b0;
        we_i     <= 1'b0;
        addr_i   <= '0;
        wdata_i  <= '0;
        be_i     <= '0;
        bypass_i <= 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[12'(i)] = fill_byte(12'(i));
        end
        apply_reset();

        // cold miss, then hits on both words of the line
        load_word(32'h0000_0040, 1'b0, EXPECT_MISS);
        load_word(32'h0000_0048, 1'b0, EXPECT_HIT);
        load_word(32'h0000_0040, 1'b0, EXPECT_HIT);

        // bypass reads memory and fills nothing
        load_word(32'h0000_0040, 1'b1, EXPECT_MISS);
        load_word(32'h0000_0080, 1'b1, EXPECT_MISS);
        load_word(32'h0000_0088, 1'b0, EXPECT_MISS);
        load_word(32'h0000_0080, 1'b0, EXPECT_HIT);

        // store hit, store miss without allocation, bypassed store to a cached line
        store_word(32'h0000_0048, 64'h1122_3344_5566_7788, 8'hf0, 1'b0);
        load_word(32'h0000_0048, 1'b0, EXPECT_HIT);
        store_word(32'h0000_00c0, 64'hdead_beef_0bad_f00d, 8'hff, 1'b0);
        load_word(32'h0000_00c0, 1'b0, EXPECT_MISS);
        store_word(32'h0000_0080, 64'h0123_4567_89ab_cdef, 8'h3c, 1'b1);
        load_word(32'h0000_0080, 1'b0, EXPECT_HIT);

        // three lines in set 2
        load_word(32'h0000_0120, 1'b0, EXPECT_MISS);
        load_word(32'h0000_0320, 1'b0, EXPECT_MISS);
        load_word(32'h0000_0520, 1'b0, EXPECT_MISS);
        load_word(32'h0000_0320, 1'b0, EXPECT_HIT);
        load_word(32'h0000_0120, 1'b0, EXPECT_MISS);
        load_word(32'h0000_0520, 1'b0, EXPECT_HIT);
        load_word(32'h0000_0320, 1'b0, EXPECT_MISS);

        // reset empties the cache
        apply_reset();
        load_word(32'h0000_0040, 1'b0, EXPECT_MISS);
        load_word(32'h0000_0520, 1'b0, EXPECT_MISS);

        // random traffic in the low KiB, four tags per set
        for (int n = 0; n < RANDOM_OPS; n++) begin
            addr   = $urandom & 32'h0000_03f8;
            we     = ($urandom % 3) == 0;
            bypass = ($urandom % 5) == 0;
            be     = 8'($urandom);
            wdata  = {$urandom, $urandom};
            if (we) begin
                store_word(addr, wdata, be, bypass);
            end else begin
                load_word(addr, bypass, EXPECT_ANY);
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== tb.f ====
design/cache_pkg.sv
design/sram_array.sv
design/tag_lookup.sv
design/line_store.sv
design/cache_ctrl.sv
design/dcache_top.sv
test/mem_model.sv
test/dcache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the data cache testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module dcache_tb \
    && ./obj_dir/Vdcache_tb | grep -F "Simulation completed successfully" \
    && echo "dcache run passed" \
    || { echo "dcache run failed"; exit 1; }
